//--- common/conv_defs.svh
// convolution datapath sizes shared by the package and every module

`ifndef CONV_DEFS_SVH
`define CONV_DEFS_SVH

// parallel lanes, one per kernel column
`define CONV_KERNEL_W 4

// signed pixel and weight width
`define CONV_DATA_W 16

// signed accumulator width
// headroom for long blocks of full scale products
`define CONV_ACC_W 40

// multiplier pipeline depth, in enabled cycles
`define CONV_MUL_DELAY 3

`endif

//--- common/conv_pkg.sv
// convolution datapath types for the input beat and the finished lane sum

`include "conv_defs.svh"

package conv_pkg;

    // one input beat of a lane
    // valid qualifies the beat, last closes a block
    // relu applies to the whole block
    typedef struct packed {
        logic                           valid;
        logic signed [`CONV_DATA_W-1:0] pixel;
        logic signed [`CONV_DATA_W-1:0] weight;
        logic                           last;
        logic                           relu;
    } beat_t;

    // one finished block result of a lane
    // relu travels with the sum, applied at the output
    typedef struct packed {
        logic                          valid;
        logic signed [`CONV_ACC_W-1:0] data;
        logic                          relu;
    } sum_t;

endpackage

//--- run.sh
#!/bin/sh
# build and run the convolution unit testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f sources.f --top-module conv_unit_tb -o conv_unit_sim

./obj_dir/conv_unit_sim | tee sim.log

if grep -q "^Result: PASSED$" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed, see sim.log"
    exit 1
fi

//--- sources.f
+incdir+common
common/conv_pkg.sv
src/mac_lane.sv
src/shift_collector.sv
src/output_stage.sv
src/conv_unit.sv
tests/conv_unit_props.sv
tests/conv_unit_tb.sv

//--- src/conv_unit.sv
// convolution unit top, parallel mac lanes drained in lane order through relu output

`timescale 1ns/1ns

`include "conv_defs.svh"

module conv_unit (
    input  logic                          aclk,
    input  logic                          arst_n,
    input  logic                          aclken,
    input  conv_pkg::beat_t               beats [`CONV_KERNEL_W],
    output logic                          m_valid,
    output logic signed [`CONV_ACC_W-1:0] m_data,
    output logic                          m_last
);

    import conv_pkg::*;

    // finished block sums, one per lane
    sum_t lane_sums [`CONV_KERNEL_W];

    // head of the shift chain, lane 0 side
    sum_t head;

    // aclken is the downstream ready
    // all three stages freeze together while it is low
    for (genvar i = 0; i < `CONV_KERNEL_W; i++) begin : lane_gen
        mac_lane u_lane (
            .aclk   (aclk),
            .arst_n (arst_n),
            .aclken (aclken),
            .beat   (beats[i]),
            .sum    (lane_sums[i])
        );
    end

    // parallel sums to a serial stream, lowest lane first
    shift_collector u_collector (
        .aclk      (aclk),
        .arst_n    (arst_n),
        .aclken    (aclken),
        .lane_sums (lane_sums),
        .head      (head)
    );

    // relu, group last marking, output register
    output_stage u_output (
        .aclk    (aclk),
        .arst_n  (arst_n),
        .aclken  (aclken),
        .head    (head),
        .m_valid (m_valid),
        .m_data  (m_data),
        .m_last  (m_last)
    );

endmodule

//--- src/mac_lane.sv
// mac lane, pipelined signed multiply and per block accumulation of the products

`timescale 1ns/1ns

`include "conv_defs.svh"

module mac_lane (
    input  logic            aclk,
    input  logic            arst_n,
    input  logic            aclken,
    input  conv_pkg::beat_t beat,
    output conv_pkg::sum_t  sum
);

    import conv_pkg::*;

    localparam int PROD_W = 2 * `CONV_DATA_W;

    // one multiplier stage, flags ride along with the product
    typedef struct packed {
        logic                     valid;
        logic signed [PROD_W-1:0] prod;
        logic                     last;
        logic                     relu;
    } mul_stage_t;

    mul_stage_t [`CONV_MUL_DELAY-1:0] pipe;

    // running total of the current block
    logic signed [`CONV_ACC_W-1:0] acc_q;
    logic signed [`CONV_ACC_W-1:0] acc_sum;

    // completed block total, one cycle ahead of sum
    sum_t total_q;

    mul_stage_t tail;

    assign tail = pipe[`CONV_MUL_DELAY-1];

    // product sign extends into the accumulator width
    assign acc_sum = acc_q + tail.prod;

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            pipe    <= '0;
            acc_q   <= '0;
            total_q <= '0;
            sum     <= '0;
        end else if (aclken) begin
            // first stage does the multiply
            pipe[0].valid <= beat.valid;
            pipe[0].prod  <= beat.pixel * beat.weight;
            pipe[0].last  <= beat.last;
            pipe[0].relu  <= beat.relu;

            // remaining stages only delay
            for (int k = 1; k < `CONV_MUL_DELAY; k++) begin
                pipe[k] <= pipe[k-1];
            end

            // accumulate, restart from zero after the last product
            if (tail.valid) begin
                acc_q <= tail.last ? '0 : acc_sum;
            end

            // block total, valid only on the last product
            total_q.valid <= tail.valid && tail.last;
            total_q.data  <= acc_sum;
            total_q.relu  <= tail.relu;

            // registered out, valid for exactly one enabled cycle
            sum <= total_q;
        end
    end

endmodule

//--- src/output_stage.sv
// output stage, relu clamp and group last marking with a registered output

`timescale 1ns/1ns

`include "conv_defs.svh"

module output_stage (
    input  logic                          aclk,
    input  logic                          arst_n,
    input  logic                          aclken,
    input  conv_pkg::sum_t                head,
    output logic                          m_valid,
    output logic signed [`CONV_ACC_W-1:0] m_data,
    output logic                          m_last
);

    localparam int CNT_W = $clog2(`CONV_KERNEL_W);
    localparam logic [CNT_W-1:0] LAST_LANE = CNT_W'(`CONV_KERNEL_W - 1);

    // lane of the next valid output
    logic [CNT_W-1:0] lane_q;

    logic signed [`CONV_ACC_W-1:0] relu_data;
    logic                          at_last_lane;

    // negative sums clamp to zero only when the block asks for it
    assign relu_data    = (head.relu && head.data[`CONV_ACC_W-1]) ? '0 : head.data;
    assign at_last_lane = (lane_q == LAST_LANE);

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            m_valid <= 1'b0;
            m_data  <= '0;
            m_last  <= 1'b0;
            lane_q  <= '0;
        end else if (aclken) begin
            m_valid <= head.valid;
            m_data  <= relu_data;
            m_last  <= head.valid && at_last_lane;
            // wraps after the highest lane
            if (head.valid) begin
                lane_q <= at_last_lane ? '0 : lane_q + 1'b1;
            end
        end
    end

endmodule

//--- src/shift_collector.sv
// shift chain collector, serializes parallel lane sums into lane order

`timescale 1ns/1ns

`include "conv_defs.svh"

module shift_collector (
    input  logic           aclk,
    input  logic           arst_n,
    input  logic           aclken,
    input  conv_pkg::sum_t lane_sums [`CONV_KERNEL_W],
    output conv_pkg::sum_t head
);

    import conv_pkg::*;

    // stage i belongs to lane i, stage 0 is the head
    sum_t [`CONV_KERNEL_W-1:0] stage_q;

    // what each stage takes when its lane is idle
    sum_t [`CONV_KERNEL_W-1:0] from_above;

    always_comb begin
        for (int i = 0; i < `CONV_KERNEL_W - 1; i++) begin
            from_above[i] = stage_q[i+1];
        end
        // nothing above the top stage, feed a bubble
        from_above[`CONV_KERNEL_W-1] = '0;
    end

    // a fresh lane sum wins over the shift
    // usage rule keeps it from landing on a sum still in flight
    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            stage_q <= '0;
        end else if (aclken) begin
            for (int i = 0; i < `CONV_KERNEL_W; i++) begin
                if (lane_sums[i].valid) begin
                    stage_q[i] <= lane_sums[i];
                end else begin
                    stage_q[i] <= from_above[i];
                end
            end
        end
    end

    // lane i reaches here i enabled cycles after loading
    assign head = stage_q[0];

endmodule

//--- tests/conv_unit_props.sv
// convolution unit port properties, reset state, last framing and stall hold

`timescale 1ns/1ns

`include "conv_defs.svh"

module conv_unit_props (
    input logic                          aclk,
    input logic                          arst_n,
    input logic                          aclken,
    input logic                          m_valid,
    input logic signed [`CONV_ACC_W-1:0] m_data,
    input logic                          m_last
);

    // output register cleared by the edge after reset was seen
    reset_quiet: assert property (@(posedge aclk) !arst_n |=> (!m_valid && !m_last))
        else $error("output active during reset");

    last_needs_valid: assert property (@(posedge aclk) disable iff (!arst_n) m_last |-> m_valid)
        else $error("m_last set without m_valid");

    // low aclken is the consumer stalling, output must hold
    stall_hold: assert property (@(posedge aclk) disable iff (!arst_n)
        !aclken |=> ($stable(m_valid) && $stable(m_data) && $stable(m_last)))
        else $error("output changed while aclken was low");

endmodule

bind conv_unit conv_unit_props u_props (
    .aclk    (aclk),
    .arst_n  (arst_n),
    .aclken  (aclken),
    .m_valid (m_valid),
    .m_data  (m_data),
    .m_last  (m_last)
);

//--- tests/conv_unit_tb.sv
// convolution unit testbench, random blocks checked against a dot product model

`timescale 1ns/1ns

`include "conv_defs.svh"

module conv_unit_tb;

    import conv_pkg::*;

    localparam int KW            = `CONV_KERNEL_W;
    localparam int MAX_LEN       = KW + 8;
    localparam int BEAT_TIMEOUT  = 64;
    localparam int DRAIN_TIMEOUT = 200;

    // one expected output, lane kept for the error line
    typedef struct packed {
        logic [7:0]                    lane;
        logic                          last;
        logic signed [`CONV_ACC_W-1:0] data;
    } expect_t;

    logic                          aclk;
    logic                          arst_n;
    logic                          aclken;
    beat_t                         beats [KW];
    logic                          m_valid;
    logic signed [`CONV_ACC_W-1:0] m_data;
    logic                          m_last;

    logic [15:0] lfsr_state;

    // operands of the block in flight, per lane
    logic signed [`CONV_DATA_W-1:0] blk_pix [KW][MAX_LEN];
    logic signed [`CONV_DATA_W-1:0] blk_wt  [KW][MAX_LEN];

    expect_t exp_q [$];

    int   data_errors;
    int   last_errors;
    int   unexpected_errors;
    int   checked;
    bit   timed_out;
    logic edge_en;

    conv_unit dut (
        .aclk    (aclk),
        .arst_n  (arst_n),
        .aclken  (aclken),
        .beats   (beats),
        .m_valid (m_valid),
        .m_data  (m_data),
        .m_last  (m_last)
    );

    always #2 aclk = ~aclk;

    // 16 bit galois lfsr, taps 16 14 13 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        logic [15:0] n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ 16'hB400;
        end
        return n;
    endfunction

    // one lfsr step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            lfsr_state = lfsr_step(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    // signed dot product of one lane, clamped when relu is set
    function automatic expect_t ref_result(input int lane, input int len, input logic relu);
        expect_t e;
        longint  acc;
        acc = 0;
        for (int k = 0; k < len; k++) begin
            acc += longint'(blk_pix[lane][k]) * longint'(blk_wt[lane][k]);
        end
        if (relu && acc < 0) begin
            acc = 0;
        end
        e.lane = 8'(lane);
        e.last = (lane == KW - 1);
        e.data = acc[`CONV_ACC_W-1:0];
        return e;
    endfunction

    // hold the current beats until an enabled edge takes them
    task automatic send_beat(input bit rand_en);
        int waited;
        bit taken;
        waited = 0;
        taken  = 0;
        while (!taken && !timed_out) begin
            // about three enabled cycles in four
            aclken = rand_en ? (rand_bits(2) != 0) : 1'b1;
            @(posedge aclk);
            taken = aclken;
            @(negedge aclk);
            waited++;
            if (!taken && waited >= BEAT_TIMEOUT) begin
                $display("timeout: beat not accepted within %0d cycles", BEAT_TIMEOUT);
                timed_out = 1;
            end
        end
    endtask

    // all lanes run one block of equal length, then expected sums are queued
    task automatic send_block(input bit rand_en);
        int   len;
        logic relu;
        len  = KW + int'(rand_bits(3));
        relu = rand_bits(1);
        for (int k = 0; k < len; k++) begin
            for (int lane = 0; lane < KW; lane++) begin
                blk_pix[lane][k]    = rand_bits(`CONV_DATA_W);
                blk_wt[lane][k]     = rand_bits(`CONV_DATA_W);
                beats[lane].valid  = 1'b1;
                beats[lane].pixel  = blk_pix[lane][k];
                beats[lane].weight = blk_wt[lane][k];
                beats[lane].last   = (k == len - 1);
                beats[lane].relu   = relu;
            end
            send_beat(rand_en);
        end
        // lane order is the drain order
        for (int lane = 0; lane < KW; lane++) begin
            exp_q.push_back(ref_result(lane, len, relu));
        end
    endtask

    // run until every queued result came out
    task automatic drain(input bit rand_en);
        int waited;
        waited = 0;
        for (int lane = 0; lane < KW; lane++) begin
            beats[lane] = '0;
        end
        while (exp_q.size() != 0 && waited < DRAIN_TIMEOUT) begin
            aclken = rand_en ? (rand_bits(2) != 0) : 1'b1;
            @(negedge aclk);
            waited++;
        end
        if (exp_q.size() != 0) begin
            $display("timeout: %0d results still missing after drain", exp_q.size());
            timed_out = 1;
        end
    endtask

    // outputs change only on an enabled edge, read them half a cycle later
    always begin : compare_proc
        expect_t e;
        @(posedge aclk);
        edge_en = aclken && arst_n;
        @(negedge aclk);
        if (edge_en && m_valid) begin
            assert (exp_q.size() != 0) else begin
                $display("FAILED at %0t ns: unexpected output with no result pending",
                         $time);
                unexpected_errors++;
            end
            if (exp_q.size() != 0) begin
                e = exp_q.pop_front();
                checked++;
                assert (m_data == e.data) else begin
                    $display("FAILED at %0t ns: lane %0d data %0d, expected %0d",
                             $time, e.lane, m_data, e.data);
                    data_errors++;
                end
                assert (m_last == e.last) else begin
                    $display("FAILED at %0t ns: lane %0d last %0b, expected %0b",
                             $time, e.lane, m_last, e.last);
                    last_errors++;
                end
            end
        end
    end

    initial begin
        aclk       = 1'b0;
        arst_n     = 1'b0;
        aclken     = 1'b0;
        lfsr_state = 16'd2341;
        timed_out  = 0;
        for (int lane = 0; lane < KW; lane++) begin
            beats[lane] = '0;
        end
        repeat (8) @(negedge aclk);
        arst_n = 1'b1;
        aclken = 1'b1;

        // idle, compare process flags any output here
        repeat (10) @(negedge aclk);

        // back to back blocks, unit always enabled
        for (int b = 0; b < 10 && !timed_out; b++) begin
            send_block(1'b0);
        end
        drain(1'b0);

        // same traffic with random stalls during input and drain
        for (int b = 0; b < 14 && !timed_out; b++) begin
            send_block(1'b1);
        end
        if (!timed_out) begin
            drain(1'b1);
        end

        // quiet tail, nothing more may come out
        aclken = 1'b1;
        repeat (12) @(negedge aclk);

        $display("errors: data=%0d last=%0d unexpected=%0d timeout=%0d, outputs checked=%0d",
                 data_errors, last_errors, unexpected_errors, timed_out, checked);
        if (data_errors == 0 && last_errors == 0 && unexpected_errors == 0 && !timed_out) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule
